// ==== Makefile ====
.PHONY: run clean

obj_dir/Vtb_decode_stage: vlog.f decode_model.svh $(wildcard *.sv)
	verilator --binary --assert --top-module tb_decode_stage -f vlog.f -o Vtb_decode_stage

run: obj_dir/Vtb_decode_stage
	./obj_dir/Vtb_decode_stage > sim.log
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== decode_pkg.sv ====
// Widths are fixed by RV32IM and SYSTEM instructions have no operation of their own here
`default_nettype none

package decode_pkg;

    // Width of the in-flight tag carried alongside each instruction
    localparam int TAG_W = 3;

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    // NOP sits at zero so a cleared issue bundle reads as a NOP
    typedef enum logic [5:0] {
        NOP,
        LUI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        INVALID
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

    // Stage input from fetch
    typedef struct packed {
        logic [31:0]      instruction;
        logic [31:0]      pc;
        logic [TAG_W-1:0] tag;
        logic             access_fault;
    } fetch_t;

    // Stage output towards execute
    typedef struct packed {
        op_e              operation;
        logic [31:0]      first_operand;
        logic [31:0]      second_operand;
        logic [31:0]      third_operand;
        logic [31:0]      pc;
        logic [31:0]      instruction;
        logic [TAG_W-1:0] tag;
        logic             illegal;
        logic             misaligned;
        logic             access_fault;
    } issue_t;

endpackage

`default_nettype wire

// ==== decode_stage.sv ====
// Decode stage top; register bank must answer rs1_o and rs2_o in the same cycle
`default_nettype none

module decode_stage (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   enable_i,
    input  wire decode_pkg::fetch_t     fetch_i,
    input  wire logic [31:0]            rs1_data_i,
    input  wire logic [31:0]            rs2_data_i,
    output logic [4:0]                  rs1_o,
    output logic [4:0]                  rs2_o,
    output logic [4:0]                  rd_o,
    output decode_pkg::issue_t          issue_o,
    output logic                        hazard_o
);

    logic [31:0]         instr;
    logic [31:0]         imm;
    logic                illegal;
    logic                accept;
    decode_pkg::op_e     op;
    decode_pkg::format_e format;

    hazard_unit hazard_unit_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .enable_i (enable_i),
        .instr_i  (fetch_i.instruction),
        .format_i (format),
        .instr_o  (instr),
        .rs1_o    (rs1_o),
        .rs2_o    (rs2_o),
        .rd_o     (rd_o),
        .hazard_o (hazard_o),
        .accept_o (accept)
    );

    op_decoder op_decoder_i (.instr_i(instr), .op_o(op), .format_o(format), .illegal_o(illegal));

    imm_gen imm_gen_i (.instr_i(instr), .format_i(format), .imm_o(imm));

    issue_register issue_register_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .hazard_i   (hazard_o),
        .accept_i   (accept),
        .fetch_i    (fetch_i),
        .instr_i    (instr),
        .op_i       (op),
        .format_i   (format),
        .imm_i      (imm),
        .illegal_i  (illegal),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .issue_o    (issue_o)
    );

endmodule

`default_nettype wire

// ==== hazard_unit.sv ====
// One-entry register lock plus store lock; fetch must hold pc, tag and fault during hazard or stall
`default_nettype none

module hazard_unit (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   enable_i,
    input  wire logic [31:0]            instr_i,
    input  wire decode_pkg::format_e    format_i,
    output logic [31:0]                 instr_o,
    output logic [4:0]                  rs1_o,
    output logic [4:0]                  rs2_o,
    output logic [4:0]                  rd_o,
    output logic                        hazard_o,
    output logic                        accept_o
);

    logic [31:0] last_instr;
    logic        last_hazard;
    logic        last_stall;
    logic [4:0]  locked_reg;
    logic        locked_mem;
    logic        is_store;
    logic        use_mem;
    logic        use_rs1;
    logic        use_rs2;

    ////////////////////////////////////////////////////////////////////
    // Replay of the held instruction
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_instr  <= decode_pkg::NOP_INSTR;
            last_hazard <= 1'b0;
            last_stall  <= 1'b0;
        end else begin
            last_instr  <= instr_o;
            last_hazard <= hazard_o;
            last_stall  <= ~enable_i;
        end
    end

    assign instr_o = (last_hazard || last_stall) ? last_instr : instr_i;
    assign rs1_o   = instr_o[19:15];
    assign rs2_o   = instr_o[24:20];

    ////////////////////////////////////////////////////////////////////
    // Lock registers
    ////////////////////////////////////////////////////////////////////

    assign is_store = (instr_o[6:0] == 7'b0100011);
    assign use_mem  = is_store || (instr_o[6:0] == 7'b0000011);

    // Hazard wins so a bubble leaves nothing locked
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
            rd_o       <= '0;
        end else begin
            rd_o <= locked_reg;
            if (hazard_o) begin
                locked_reg <= '0;
                locked_mem <= 1'b0;
            end else if (accept_o) begin
                locked_reg <= instr_o[11:7];
                locked_mem <= is_store;
            end
        end
    end

    // Source usage by format, U and J read no register
    assign use_rs1 = (format_i != decode_pkg::U_TYPE) && (format_i != decode_pkg::J_TYPE);
    assign use_rs2 = (format_i == decode_pkg::R_TYPE) || (format_i == decode_pkg::B_TYPE) ||
                     (format_i == decode_pkg::S_TYPE);

    assign hazard_o = enable_i && ((locked_mem && use_mem) ||
                      (use_rs1 && rs1_o != 5'd0 && rs1_o == locked_reg) ||
                      (use_rs2 && rs2_o != 5'd0 && rs2_o == locked_reg));
    assign accept_o = enable_i && !hazard_o;

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
// Combinational immediate for RV32I formats; R format yields zero
`default_nettype none

module imm_gen (
    input  wire logic [31:0]            instr_i,
    input  wire decode_pkg::format_e    format_i,
    output logic [31:0]                 imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (format_i)
            decode_pkg::I_TYPE: imm_o = {{21{sign}}, instr_i[30:20]};
            decode_pkg::S_TYPE: imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
            // Branch offsets are halfword aligned
            decode_pkg::B_TYPE: imm_o = {{20{sign}}, instr_i[7], instr_i[30:25],
                                         instr_i[11:8], 1'b0};
            decode_pkg::U_TYPE: imm_o = {instr_i[31:12], 12'b0};
            decode_pkg::J_TYPE: imm_o = {{12{sign}}, instr_i[19:12], instr_i[20],
                                         instr_i[30:21], 1'b0};
            default:            imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== issue_register.sv ====
// One-cycle issue register; holds its value while neither hazard nor accept is set
`default_nettype none

module issue_register (
    input  wire logic                   clk,
    input  wire logic                   reset_n,
    input  wire logic                   hazard_i,
    input  wire logic                   accept_i,
    input  wire decode_pkg::fetch_t     fetch_i,
    input  wire logic [31:0]            instr_i,
    input  wire decode_pkg::op_e        op_i,
    input  wire decode_pkg::format_e    format_i,
    input  wire logic [31:0]            imm_i,
    input  wire logic                   illegal_i,
    input  wire logic [31:0]            rs1_data_i,
    input  wire logic [31:0]            rs2_data_i,
    output decode_pkg::issue_t          issue_o
);

    logic [31:0] first;
    logic [31:0] second;
    logic [31:0] third;

    ////////////////////////////////////////////////////////////////////
    // Operand selection
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (format_i)
            decode_pkg::U_TYPE, decode_pkg::J_TYPE: begin
                first  = fetch_i.pc;
                second = imm_i;
                third  = imm_i;
            end
            decode_pkg::R_TYPE, decode_pkg::B_TYPE: begin
                first  = rs1_data_i;
                second = rs2_data_i;
                third  = imm_i;
            end
            // Store data rides in the third operand
            decode_pkg::S_TYPE: begin
                first  = rs1_data_i;
                second = imm_i;
                third  = rs2_data_i;
            end
            default: begin
                first  = rs1_data_i;
                second = imm_i;
                third  = imm_i;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            issue_o           <= '0;
            issue_o.operation <= decode_pkg::NOP;
        end else if (hazard_i) begin
            // Bubble keeps the tag of the stalled fetch
            issue_o           <= '0;
            issue_o.operation <= decode_pkg::NOP;
            issue_o.tag       <= fetch_i.tag;
        end else if (accept_i) begin
            issue_o.operation      <= op_i;
            issue_o.first_operand  <= first;
            issue_o.second_operand <= second;
            issue_o.third_operand  <= third;
            issue_o.pc             <= fetch_i.pc;
            issue_o.instruction    <= instr_i;
            issue_o.tag            <= fetch_i.tag;
            issue_o.illegal        <= illegal_i;
            issue_o.misaligned     <= (fetch_i.pc[1:0] != 2'b00);
            issue_o.access_fault   <= fetch_i.access_fault;
        end
    end

endmodule

`default_nettype wire

// ==== op_decoder.sv ====
// Purely combinational; all SYSTEM opcodes and unlisted encodings come out as INVALID
`default_nettype none

module op_decoder (
    input  wire logic [31:0]        instr_i,
    output decode_pkg::op_e         op_o,
    output decode_pkg::format_e     format_o,
    output logic                    illegal_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    decode_pkg::op_e op_branch;
    decode_pkg::op_e op_load;
    decode_pkg::op_e op_store;
    decode_pkg::op_e op_imm;
    decode_pkg::op_e op_reg;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    ////////////////////////////////////////////////////////////////////
    // Operation within each opcode class
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  op_branch = decode_pkg::BEQ;
            3'b001:  op_branch = decode_pkg::BNE;
            3'b100:  op_branch = decode_pkg::BLT;
            3'b101:  op_branch = decode_pkg::BGE;
            3'b110:  op_branch = decode_pkg::BLTU;
            3'b111:  op_branch = decode_pkg::BGEU;
            default: op_branch = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = decode_pkg::LB;
            3'b001:  op_load = decode_pkg::LH;
            3'b010:  op_load = decode_pkg::LW;
            3'b100:  op_load = decode_pkg::LBU;
            3'b101:  op_load = decode_pkg::LHU;
            default: op_load = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_store = decode_pkg::SB;
            3'b001:  op_store = decode_pkg::SH;
            3'b010:  op_store = decode_pkg::SW;
            default: op_store = decode_pkg::INVALID;
        endcase
    end

    // Shifts are the only immediate ops that constrain funct7
    always_comb begin
        casez ({funct7, funct3})
            10'b???????_000: op_imm = decode_pkg::ADD;
            10'b0000000_001: op_imm = decode_pkg::SLL;
            10'b???????_010: op_imm = decode_pkg::SLT;
            10'b???????_011: op_imm = decode_pkg::SLTU;
            10'b???????_100: op_imm = decode_pkg::XOR;
            10'b0000000_101: op_imm = decode_pkg::SRL;
            10'b0100000_101: op_imm = decode_pkg::SRA;
            10'b???????_110: op_imm = decode_pkg::OR;
            10'b???????_111: op_imm = decode_pkg::AND;
            default:         op_imm = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: op_reg = decode_pkg::ADD;
            10'b0100000_000: op_reg = decode_pkg::SUB;
            10'b0000000_001: op_reg = decode_pkg::SLL;
            10'b0000000_010: op_reg = decode_pkg::SLT;
            10'b0000000_011: op_reg = decode_pkg::SLTU;
            10'b0000000_100: op_reg = decode_pkg::XOR;
            10'b0000000_101: op_reg = decode_pkg::SRL;
            10'b0100000_101: op_reg = decode_pkg::SRA;
            10'b0000000_110: op_reg = decode_pkg::OR;
            10'b0000000_111: op_reg = decode_pkg::AND;
            // M extension
            10'b0000001_000: op_reg = decode_pkg::MUL;
            10'b0000001_001: op_reg = decode_pkg::MULH;
            10'b0000001_010: op_reg = decode_pkg::MULHSU;
            10'b0000001_011: op_reg = decode_pkg::MULHU;
            10'b0000001_100: op_reg = decode_pkg::DIV;
            10'b0000001_101: op_reg = decode_pkg::DIVU;
            10'b0000001_110: op_reg = decode_pkg::REM;
            10'b0000001_111: op_reg = decode_pkg::REMU;
            default:         op_reg = decode_pkg::INVALID;
        endcase
    end

    ////////////////////////////////////////////////////////////////////
    // Opcode class and format
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            7'b0110111: op_o = decode_pkg::LUI;
            7'b0010111: op_o = decode_pkg::ADD;     // AUIPC adds to pc
            7'b1101111: op_o = decode_pkg::JAL;
            7'b1100111: op_o = decode_pkg::JALR;
            7'b1100011: op_o = op_branch;
            7'b0000011: op_o = op_load;
            7'b0100011: op_o = op_store;
            7'b0010011: op_o = op_imm;
            7'b0110011: op_o = op_reg;
            7'b0001111: op_o = (funct3 == 3'b000) ? decode_pkg::NOP : decode_pkg::INVALID;
            default:    op_o = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        case (opcode)
            7'b1100111, 7'b0000011, 7'b0010011: format_o = decode_pkg::I_TYPE;
            7'b0100011:                         format_o = decode_pkg::S_TYPE;
            7'b1100011:                         format_o = decode_pkg::B_TYPE;
            7'b0110111, 7'b0010111:             format_o = decode_pkg::U_TYPE;
            7'b1101111:                         format_o = decode_pkg::J_TYPE;
            default:                            format_o = decode_pkg::R_TYPE;
        endcase
    end

    assign illegal_o = (op_o == decode_pkg::INVALID);

endmodule

`default_nettype wire

// ==== decode_model.svh ====
// Reference model of the decode stage; assumes the caller holds pc, tag and fault on hazard or stall
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

logic [31:0]        m_last_instr;
logic               m_last_hazard;
logic               m_last_stall;
logic [4:0]         m_lock;
logic               m_lock_mem;
logic [4:0]         m_rd;
logic               m_hazard;
logic [31:0]        m_sel;
decode_pkg::issue_t m_issue;

// Register-register and immediate ALU ops share this funct3 order
function automatic decode_pkg::op_e alu_op(input logic [2:0] f3);
    case (f3)
        3'd0:    return decode_pkg::ADD;
        3'd1:    return decode_pkg::SLL;
        3'd2:    return decode_pkg::SLT;
        3'd3:    return decode_pkg::SLTU;
        3'd4:    return decode_pkg::XOR;
        3'd5:    return decode_pkg::SRL;
        3'd6:    return decode_pkg::OR;
        default: return decode_pkg::AND;
    endcase
endfunction

function automatic decode_pkg::op_e mul_op(input logic [2:0] f3);
    case (f3)
        3'd0:    return decode_pkg::MUL;
        3'd1:    return decode_pkg::MULH;
        3'd2:    return decode_pkg::MULHSU;
        3'd3:    return decode_pkg::MULHU;
        3'd4:    return decode_pkg::DIV;
        3'd5:    return decode_pkg::DIVU;
        3'd6:    return decode_pkg::REM;
        default: return decode_pkg::REMU;
    endcase
endfunction

function automatic decode_pkg::op_e ref_op(input logic [31:0] w);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = w[14:12];
    f7 = w[31:25];
    case (w[6:0])
        7'h37: return decode_pkg::LUI;
        7'h17: return decode_pkg::ADD;
        7'h6f: return decode_pkg::JAL;
        7'h67: return decode_pkg::JALR;
        7'h0f: return (f3 == 3'd0) ? decode_pkg::NOP : decode_pkg::INVALID;
        7'h63: begin
            case (f3)
                3'd0:    return decode_pkg::BEQ;
                3'd1:    return decode_pkg::BNE;
                3'd4:    return decode_pkg::BLT;
                3'd5:    return decode_pkg::BGE;
                3'd6:    return decode_pkg::BLTU;
                3'd7:    return decode_pkg::BGEU;
                default: return decode_pkg::INVALID;
            endcase
        end
        7'h03: begin
            case (f3)
                3'd0:    return decode_pkg::LB;
                3'd1:    return decode_pkg::LH;
                3'd2:    return decode_pkg::LW;
                3'd4:    return decode_pkg::LBU;
                3'd5:    return decode_pkg::LHU;
                default: return decode_pkg::INVALID;
            endcase
        end
        7'h23: begin
            case (f3)
                3'd0:    return decode_pkg::SB;
                3'd1:    return decode_pkg::SH;
                3'd2:    return decode_pkg::SW;
                default: return decode_pkg::INVALID;
            endcase
        end
        7'h13: begin
            if (f3 == 3'd1)
                return (f7 == 7'h00) ? decode_pkg::SLL : decode_pkg::INVALID;
            if (f3 == 3'd5) begin
                if (f7 == 7'h00)
                    return decode_pkg::SRL;
                return (f7 == 7'h20) ? decode_pkg::SRA : decode_pkg::INVALID;
            end
            return alu_op(f3);
        end
        7'h33: begin
            if (f7 == 7'h00)
                return alu_op(f3);
            if (f7 == 7'h01)
                return mul_op(f3);
            if (f7 == 7'h20 && f3 == 3'd0)
                return decode_pkg::SUB;
            if (f7 == 7'h20 && f3 == 3'd5)
                return decode_pkg::SRA;
            return decode_pkg::INVALID;
        end
        default: return decode_pkg::INVALID;
    endcase
endfunction

function automatic decode_pkg::format_e ref_fmt(input logic [31:0] w);
    case (w[6:0])
        7'h67, 7'h03, 7'h13: return decode_pkg::I_TYPE;
        7'h23:               return decode_pkg::S_TYPE;
        7'h63:               return decode_pkg::B_TYPE;
        7'h37, 7'h17:        return decode_pkg::U_TYPE;
        7'h6f:               return decode_pkg::J_TYPE;
        default:             return decode_pkg::R_TYPE;
    endcase
endfunction

function automatic logic [31:0] ref_imm(input logic [31:0] w, input decode_pkg::format_e f);
    case (f)
        decode_pkg::I_TYPE: return {{20{w[31]}}, w[31:20]};
        decode_pkg::S_TYPE: return {{20{w[31]}}, w[31:25], w[11:7]};
        decode_pkg::B_TYPE: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        decode_pkg::U_TYPE: return {w[31:12], 12'b0};
        decode_pkg::J_TYPE: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        default:            return 32'd0;
    endcase
endfunction

task automatic model_reset();
    m_last_instr      = decode_pkg::NOP_INSTR;
    m_last_hazard     = 1'b0;
    m_last_stall      = 1'b0;
    m_lock            = 5'd0;
    m_lock_mem        = 1'b0;
    m_rd              = 5'd0;
    m_hazard          = 1'b0;
    m_sel             = 32'd0;
    m_issue           = '0;
    m_issue.operation = decode_pkg::NOP;
endtask

// One clock edge of the stage for the inputs now applied
task automatic model_step(input logic en, input decode_pkg::fetch_t f,
                          input logic [31:0] d1, input logic [31:0] d2);
    decode_pkg::format_e fmt;
    logic [31:0]         imm;
    logic                use1;
    logic                use2;
    logic                st;
    logic                mem;
    m_sel = (m_last_hazard || m_last_stall) ? m_last_instr : f.instruction;
    fmt   = ref_fmt(m_sel);
    imm   = ref_imm(m_sel, fmt);
    use1  = fmt inside {decode_pkg::R_TYPE, decode_pkg::I_TYPE, decode_pkg::S_TYPE,
                        decode_pkg::B_TYPE};
    use2  = fmt inside {decode_pkg::R_TYPE, decode_pkg::S_TYPE, decode_pkg::B_TYPE};
    st    = (m_sel[6:0] == 7'h23);
    mem   = st || (m_sel[6:0] == 7'h03);
    m_hazard = en && ((m_lock_mem && mem) ||
               (use1 && m_sel[19:15] != 5'd0 && m_sel[19:15] == m_lock) ||
               (use2 && m_sel[24:20] != 5'd0 && m_sel[24:20] == m_lock));
    m_rd = m_lock;
    if (m_hazard) begin
        m_issue           = '0;
        m_issue.operation = decode_pkg::NOP;
        m_issue.tag       = f.tag;
        m_lock            = 5'd0;
        m_lock_mem        = 1'b0;
    end else if (en) begin
        m_issue.operation    = ref_op(m_sel);
        m_issue.pc           = f.pc;
        m_issue.instruction  = m_sel;
        m_issue.tag          = f.tag;
        m_issue.illegal      = (ref_op(m_sel) == decode_pkg::INVALID);
        m_issue.misaligned   = (f.pc[1:0] != 2'b00);
        m_issue.access_fault = f.access_fault;
        case (fmt)
            decode_pkg::U_TYPE, decode_pkg::J_TYPE: begin
                m_issue.first_operand  = f.pc;
                m_issue.second_operand = imm;
                m_issue.third_operand  = imm;
            end
            decode_pkg::S_TYPE: begin
                m_issue.first_operand  = d1;
                m_issue.second_operand = imm;
                m_issue.third_operand  = d2;
            end
            decode_pkg::I_TYPE: begin
                m_issue.first_operand  = d1;
                m_issue.second_operand = imm;
                m_issue.third_operand  = imm;
            end
            default: begin
                m_issue.first_operand  = d1;
                m_issue.second_operand = d2;
                m_issue.third_operand  = imm;
            end
        endcase
        m_lock     = m_sel[11:7];
        m_lock_mem = st;
    end
    m_last_instr  = m_sel;
    m_last_hazard = m_hazard;
    m_last_stall  = !en;
endtask

`endif

// ==== tb_decode_stage.sv ====
// Random test of the decode stage from a fixed seed; fetch fields are held while hazard or stall
`default_nettype none

module tb_decode_stage;

    localparam int N_DECODE   = 400;
    localparam int N_OPERANDS = 300;
    localparam int N_HAZARD   = 300;
    localparam int N_STALL    = 300;
    localparam int N_FLAGS    = 200;
    localparam int N_TOTAL    = 6 + N_DECODE + N_OPERANDS + N_HAZARD + N_STALL + N_FLAGS;

    logic               clk;
    logic               reset_n;
    logic               enable_i;
    decode_pkg::fetch_t fetch_i;
    logic [31:0]        rs1_data_i;
    logic [31:0]        rs2_data_i;
    logic [4:0]         rs1_o;
    logic [4:0]         rs2_o;
    logic [4:0]         rd_o;
    decode_pkg::issue_t issue_o;
    logic               hazard_o;

    integer seed;
    int     errors;
    int     checks;

    `include "decode_model.svh"

    decode_stage dut_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .enable_i   (enable_i),
        .fetch_i    (fetch_i),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .rs1_o      (rs1_o),
        .rs2_o      (rs2_o),
        .rd_o       (rd_o),
        .issue_o    (issue_o),
        .hazard_o   (hazard_o)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_registered();
        checks++;
        assert (issue_o === m_issue) else begin
            $display("[FAIL] t=%0t issue_o got %h expected %h", $time, issue_o, m_issue);
            errors++;
        end
        check_field("rd_o", 32'(rd_o), 32'(m_rd));
    endtask

    // Combinational outputs for the inputs just applied
    task automatic check_comb();
        check_field("hazard_o", 32'(hazard_o), 32'(m_hazard));
        check_field("rs1_o", 32'(rs1_o), 32'(m_sel[19:15]));
        check_field("rs2_o", 32'(rs2_o), 32'(m_sel[24:20]));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    // Class templates with random fields, plus SYSTEM and raw words
    function automatic logic [31:0] rand_instr(input bit narrow);
        logic [31:0] w;
        logic [31:0] r;
        logic [3:0]  pick;
        w    = $random(seed);
        r    = $random(seed);
        pick = r[3:0];
        case (pick)
            4'd0:  w[6:0] = 7'h37;
            4'd1:  w[6:0] = 7'h17;
            4'd2:  w[6:0] = 7'h6f;
            4'd3:  begin
                w[6:0]   = 7'h67;
                w[14:12] = 3'd0;
            end
            4'd4:  w[6:0] = 7'h63;
            4'd5:  w[6:0] = 7'h03;
            4'd6:  w[6:0] = 7'h23;
            4'd7, 4'd8, 4'd14: begin
                w[6:0]   = 7'h13;
                w[31:25] = r[4] ? 7'h20 : 7'h00;
            end
            4'd9, 4'd10: begin
                w[6:0]   = 7'h33;
                w[31:25] = (r[5:4] == 2'd0) ? 7'h20 : (r[5] ? 7'h01 : 7'h00);
            end
            4'd11: begin
                w[6:0]   = 7'h0f;
                w[14:12] = 3'd0;
            end
            4'd12: w[6:0] = 7'h73;
            default: ;
        endcase
        // Few registers so that dependent pairs are common
        if (narrow) begin
            w[11:10] = 2'b00;
            w[19:18] = 2'b00;
            w[24:23] = 2'b00;
        end
        return w;
    endfunction

    task automatic drive_inputs(input bit heavy_stall, input bit narrow, input bit odd_pc);
        logic [31:0] r;
        r          = $random(seed);
        enable_i   = heavy_stall ? (r[1:0] != 2'd0) : (r[2:0] != 3'd0);
        rs1_data_i = $random(seed);
        rs2_data_i = $random(seed);
        fetch_i.instruction = rand_instr(narrow);
        if (!(m_last_hazard || m_last_stall)) begin
            r = $random(seed);
            fetch_i.pc = odd_pc ? r : {r[31:2], 2'b00};
            r = $random(seed);
            fetch_i.tag          = r[2:0];
            fetch_i.access_fault = (r[7:4] == 4'd0);
        end
    endtask

    task automatic run_test(input string name, input int n, input bit heavy_stall,
                            input bit narrow, input bit odd_pc);
        int start;
        start = errors;
        repeat (n) begin
            drive_inputs(heavy_stall, narrow, odd_pc);
            #1;
            model_step(enable_i, fetch_i, rs1_data_i, rs2_data_i);
            check_comb();
            @(negedge clk);
            check_registered();
        end
        $display("%s: %0d cycles, %0d errors", name, n, errors - start);
    endtask

    initial begin
        #(N_TOTAL * 40 + 400);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed       = 32'h99ce;
        errors     = 0;
        checks     = 0;
        clk        = 1'b0;
        reset_n    = 1'b0;
        enable_i   = 1'b1;
        fetch_i    = '0;
        // Store reading x1 and x2 while reset clears both locks
        fetch_i.instruction = 32'h0020_a023;
        rs1_data_i = 32'd0;
        rs2_data_i = 32'd0;
        model_reset();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        check_registered();
        check_field("hazard_o", 32'(hazard_o), 32'd0);
        $display("reset: %0d errors", errors);
        run_test("decode", N_DECODE, 1'b0, 1'b0, 1'b0);
        run_test("operands", N_OPERANDS, 1'b0, 1'b0, 1'b0);
        run_test("hazard", N_HAZARD, 1'b0, 1'b1, 1'b0);
        run_test("stall and replay", N_STALL, 1'b1, 1'b1, 1'b0);
        run_test("flags and destination", N_FLAGS, 1'b0, 1'b1, 1'b1);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
decode_pkg.sv
op_decoder.sv
imm_gen.sv
hazard_unit.sv
issue_register.sv
decode_stage.sv
tb_decode_stage.sv
